// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_calc
FILELIST  = sources.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== calc_alu.sv ====
`timescale 1ns/1ps
// Unsigned only; divide takes DATA_W+1 clocks, other ops one; start must wait for done
module calc_alu import calc_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     alu_start,
	input  alu_req_t alu_req,
	output logic     alu_done,
	output alu_rsp_t alu_rsp
);
	localparam int CNT_W = $clog2(DATA_W + 1);

	logic [CNT_W-1:0]  busy_cnt;          // Divide steps left
	logic [DATA_W-1:0] quo_q, rem_q, dvs_q;
	logic [DATA_W:0]   rem_sh, diff;
	logic [DATA_W-1:0] quo_nx, rem_nx;

	// ----------------------------------------------------------
	// One restoring step
	// ----------------------------------------------------------
	always_comb
	begin
		rem_sh = {rem_q, quo_q[DATA_W-1]};
		diff   = rem_sh - {1'b0, dvs_q};
		if (diff[DATA_W])
		begin
			rem_nx = rem_sh[DATA_W-1:0];  // Borrow, restore
			quo_nx = {quo_q[DATA_W-2:0], 1'b0};
		end
		else
		begin
			rem_nx = diff[DATA_W-1:0];
			quo_nx = {quo_q[DATA_W-2:0], 1'b1};
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy_cnt <= '0;
			alu_done <= 1'b0;
		end
		else
		begin
			alu_done <= 1'b0;
			if (alu_start)
			begin
				if (alu_req.op == OP_DIV && alu_req.b != '0)
					busy_cnt <= CNT_W'(DATA_W);
				else
					alu_done <= 1'b1;  // Single cycle, or zero divisor
			end
			else if (busy_cnt != '0)
			begin
				busy_cnt <= busy_cnt - 1'b1;
				alu_done <= (busy_cnt == CNT_W'(1));
			end
		end
	end

	// Operands and result
	always_ff @(posedge clk)
	begin
		if (alu_start)
		begin
			quo_q <= alu_req.a;  // Dividend shifts out as quotient shifts in
			rem_q <= '0;
			dvs_q <= alu_req.b;
			alu_rsp.div_zero <= 1'b0;
			case (alu_req.op)
				OP_ADD: alu_rsp.result <= alu_req.a + alu_req.b;
				OP_SUB: alu_rsp.result <= alu_req.a - alu_req.b;
				OP_MUL: alu_rsp.result <= alu_req.a * alu_req.b;  // Low half kept
				OP_DIV:
				begin
					alu_rsp.result   <= '0;
					alu_rsp.div_zero <= (alu_req.b == '0);
				end
			endcase
		end
		else if (busy_cnt != '0)
		begin
			quo_q <= quo_nx;
			rem_q <= rem_nx;
			if (busy_cnt == CNT_W'(1))
				alu_rsp.result <= quo_nx;
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
		alu_start |-> busy_cnt == '0);

endmodule

// ==== calc_ctrl.sv ====
`timescale 1ns/1ps
// Left-to-right evaluation, no precedence; digit entry wraps silently modulo 2**DATA_W
module calc_ctrl import calc_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              key_req,
	input  key_event_t        key_evt,
	input  logic              alu_done,
	input  alu_rsp_t          alu_rsp,
	output logic              key_ack,
	output logic              alu_start,
	output alu_req_t          alu_req,
	output logic [DATA_W-1:0] disp_value,
	output logic              err
);
	calc_state_t       state;
	logic [DATA_W-1:0] op_a, op_b;
	alu_op_t           pend_op;   // Operation waiting for B
	logic              chain;     // Result goes on as A
	logic              key_fire;  // Event taken this cycle
	logic              is_digit, is_oper, launch;
	logic [DATA_W-1:0] digit;
	alu_op_t           key_op;

	function automatic logic [DATA_W-1:0] acc10(input logic [DATA_W-1:0] v,
						    input logic [DATA_W-1:0] d);
		return v * DATA_W'(10) + d;
	endfunction

	assign key_fire = key_req && key_ack;  // First cycle of ack only
	assign is_digit = key_evt.code <= K_9;
	assign is_oper  = key_evt.code inside {K_ADD, K_SUB, K_MUL, K_DIV};
	assign digit    = DATA_W'(key_evt.code);
	assign key_op   = alu_op_t'(2'(key_evt.code - K_ADD));
	assign launch   = key_fire && state == ST_ENTER_B && (is_oper || key_evt.code == K_EQ);

	// Ack held off while the ALU runs
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			key_ack <= 1'b0;
		else if (!key_req)
			key_ack <= 1'b0;
		else if (state != ST_WAIT_ALU)
			key_ack <= 1'b1;
	end

	// ----------------------------------------------------------
	// Main FSM
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state      <= ST_ENTER_A;
			op_a       <= '0;
			op_b       <= '0;
			pend_op    <= OP_ADD;
			chain      <= 1'b0;
			alu_start  <= 1'b0;
			disp_value <= '0;
			err        <= 1'b0;
		end
		else
		begin
			alu_start <= 1'b0;
			if (alu_start)
				state <= ST_WAIT_ALU;  // Start pulse out, now wait
			else if (state == ST_WAIT_ALU)
			begin
				if (alu_done && alu_rsp.div_zero)
				begin
					err   <= 1'b1;
					state <= ST_ERROR;
				end
				else if (alu_done)
				begin
					op_a       <= alu_rsp.result;
					op_b       <= '0;
					disp_value <= alu_rsp.result;
					state      <= chain ? ST_ENTER_B : ST_SHOW;
				end
			end
			else if (key_fire && key_evt.code == K_CLR)
			begin
				op_a       <= '0;
				op_b       <= '0;
				disp_value <= '0;
				err        <= 1'b0;
				state      <= ST_ENTER_A;
			end
			else if (launch)
			begin
				alu_start <= 1'b1;
				chain     <= is_oper;
				if (is_oper)
					pend_op <= key_op;  // Old op already in the request
			end
			else if (key_fire && state != ST_ERROR)  // Error state drops the rest
			begin
				if (is_digit && state == ST_ENTER_B)
				begin
					op_b       <= acc10(op_b, digit);
					disp_value <= acc10(op_b, digit);
				end
				else if (is_digit)
				begin
					op_a       <= (state == ST_SHOW) ? digit : acc10(op_a, digit);
					disp_value <= (state == ST_SHOW) ? digit : acc10(op_a, digit);
					state      <= ST_ENTER_A;
				end
				else if (is_oper)
				begin
					pend_op <= key_op;  // A or last result
					op_b    <= '0;
					state   <= ST_ENTER_B;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			alu_req <= '{op: pend_op, a: op_a, b: op_b};
	end

	a_ack_on_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(key_ack) |-> key_req && $past(key_req));
	// Only a launched run may answer
	a_done_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
		alu_done |-> state == ST_WAIT_ALU);

endmodule

// ==== calc_painter.sv ====
`timescale 1ns/1ps
// Colour is valid only while pixel_tick is high; fixed 640x480 layout, 32x64 glyph scale
module calc_painter import calc_pkg::*; (
	input  logic [9:0]  pix_x,
	input  logic [9:0]  pix_y,
	input  logic        pixel_tick,
	input  logic [9:0]  mouse_x,
	input  logic [9:0]  mouse_y,
	input  logic [7:0]  font_word,
	input  logic [15:0] disp_value,
	input  logic        err,
	output logic [10:0] rom_addr,
	output rgb_t        rgb_next
);
	localparam int NUMERAL_X = 175;  // Grid corner
	localparam int NUMERAL_Y = 190;
	localparam int CELL      = 63;
	localparam int BAR_W     = 2;
	localparam int READ_ROW  = 1;    // Readout row, pix_y / 64
	localparam int READ_COL0 = 3;    // First readout digit, pix_x / 32

	int         px, py, mx, my;
	logic       bar_on, cursor_on, key_on, read_on, font_bit;
	key_code_t  key_code;
	logic [1:0] dig_sel;
	logic [3:0] nibble;
	logic [6:0] char_code;
	logic [2:0] bit_addr;

	function automatic logic [6:0] hex_char(input logic [3:0] n);
		return (n < 4'd10) ? 7'h30 + 7'(n) : 7'h37 + 7'(n);  // 0-9, A-F
	endfunction

	function automatic logic [6:0] key_char(input key_code_t k);
		case (k)
			K_ADD:   return 7'h2B;
			K_SUB:   return 7'h2D;
			K_MUL:   return 7'h78;
			K_DIV:   return 7'h2F;
			K_EQ:    return 7'h3D;
			K_CLR:   return 7'h43;
			default: return 7'h30 + 7'(k);  // Digits
		endcase
	endfunction

	assign px = int'(pix_x);
	assign py = int'(pix_y);
	assign mx = int'(mouse_x);
	assign my = int'(mouse_y);

	// ----------------------------------------------------------
	// Grid bars, two left columns reach down to the zero key
	// ----------------------------------------------------------
	always_comb
	begin
		bar_on = 1'b0;
		for (int k = 0; k < 6; k++)
		begin
			if (px > NUMERAL_X + k * CELL && px < NUMERAL_X + k * CELL + BAR_W + 1 &&
			    py > NUMERAL_Y && py < NUMERAL_Y + ((k < 2) ? 4 : 3) * CELL)
				bar_on = 1'b1;
		end
		for (int k = 0; k < 5; k++)
		begin
			if (py > NUMERAL_Y + k * CELL && py < NUMERAL_Y + k * CELL + BAR_W &&
			    px > NUMERAL_X &&
			    px < ((k == 4) ? NUMERAL_X + CELL + 2 : NUMERAL_X + 5 * CELL))
				bar_on = 1'b1;
		end
	end

	assign cursor_on = px > mx && px < mx + 5 && py > my && py < my + 5;  // Small box

	always_comb
	begin
		key_on = key_map(pix_y[9:6], pix_x[9:5], key_code);
	end

	// Hex readout, most significant digit first
	assign read_on = pix_y[9:6] == 4'(READ_ROW) && pix_x[9:5] >= 5'(READ_COL0) &&
			 pix_x[9:5] < 5'(READ_COL0 + 4);
	assign dig_sel = 2'(pix_x[9:5] - 5'(READ_COL0));

	always_comb
	begin
		case (dig_sel)
			2'd0: nibble = disp_value[15:12];
			2'd1: nibble = disp_value[11:8];
			2'd2: nibble = disp_value[7:4];
			default: nibble = disp_value[3:0];
		endcase
		char_code = 7'h00;
		if (read_on)
			char_code = err ? 7'h45 : hex_char(nibble);  // All E on error
		else if (key_on)
			char_code = key_char(key_code);
	end

	// Glyph lookup, 4x scale
	assign rom_addr = {char_code, pix_y[5:2]};
	assign bit_addr = pix_x[4:2];
	assign font_bit = font_word[~bit_addr];

	// ----------------------------------------------------------
	// Colour priority
	// ----------------------------------------------------------
	always_comb
	begin
		rgb_next = BLACK;
		if (pixel_tick)  // Quiet between ticks
		begin
			if (cursor_on)
				rgb_next = GREEN;
			else if (bar_on)
				rgb_next = (px < NUMERAL_X + 3 * CELL) ? LIGHTBLUE : PINK;  // Operators pink
			else if ((key_on || read_on) && font_bit)
				rgb_next = WHITE;
		end
	end

endmodule

// ==== calc_pkg.sv ====
// Shared calculator types; data path fixed at 16 bits unsigned, 3-bit RGB, 32x64 key cells
package calc_pkg;

	// ----------------------------------------------------------
	// Keys, ALU operations, controller states
	// ----------------------------------------------------------
	typedef enum logic [3:0] {
		K_0, K_1, K_2, K_3, K_4, K_5, K_6, K_7, K_8, K_9,
		K_ADD, K_SUB, K_MUL, K_DIV, K_EQ, K_CLR
	} key_code_t;  // Digit codes equal their value

	typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_DIV} alu_op_t;  // Same order as keys

	typedef enum logic [2:0] {
		ST_ENTER_A, ST_ENTER_B, ST_WAIT_ALU, ST_SHOW, ST_ERROR
	} calc_state_t;

	typedef struct packed {
		key_code_t code;
	} key_event_t;

	typedef struct packed {
		alu_op_t     op;
		logic [15:0] a;
		logic [15:0] b;
	} alu_req_t;

	typedef struct packed {
		logic [15:0] result;
		logic        div_zero;   // Quotient undefined when set
	} alu_rsp_t;

	// Colours, one bit per gun
	typedef logic [2:0] rgb_t;
	localparam rgb_t BLACK     = 3'b000;
	localparam rgb_t GREEN     = 3'b010;
	localparam rgb_t WHITE     = 3'b111;
	localparam rgb_t LIGHTBLUE = 3'b011;
	localparam rgb_t PINK      = 3'b101;

	// ----------------------------------------------------------
	// Keypad layout
	// ----------------------------------------------------------
	localparam int KEY_ROW0 = 3;  // pix_y / 64
	localparam int KEY_COL0 = 6;  // pix_x / 32, every second column

	// Rows 3 to 5, five columns each
	localparam key_code_t KEY_LUT [15] = '{
		K_7, K_8, K_9, K_MUL, K_DIV,
		K_4, K_5, K_6, K_ADD, K_SUB,
		K_1, K_2, K_3, K_CLR, K_EQ
	};

	// Returns 1 when the cell holds a key
	function automatic logic key_map(input logic [3:0] row, input logic [4:0] col,
					 output key_code_t code);
		logic [4:0] c;
		logic [3:0] r;
		c = (col - 5'(KEY_COL0)) >> 1;
		r = row - 4'(KEY_ROW0);
		code = K_0;
		key_map = 1'b0;
		if (!col[0] && col >= 5'(KEY_COL0) && row >= 4'(KEY_ROW0) && c < 5'd5)
		begin
			if (r < 4'd3)
			begin
				code = KEY_LUT[int'(r) * 5 + int'(c)];
				key_map = 1'b1;
			end
			else if (r == 4'd3 && c == 5'd0)
				key_map = 1'b1;  // Lone zero key
		end
	endfunction

endpackage

// ==== calc_top.sv ====
`timescale 1ns/1ps
// Mouse position and click are plain inputs; rgb lags the pixel counters by one tick
module calc_top import calc_pkg::*; #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33,
	parameter int DATA_W   = 16
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [9:0]        mouse_x,
	input  logic [9:0]        mouse_y,
	input  logic              click,
	output logic              hsync,
	output logic              vsync,
	output rgb_t              rgb,
	output logic [DATA_W-1:0] disp_value,
	output logic              err
);
	logic [9:0]  pix_x, pix_y;
	logic        pixel_tick, video_on;
	logic [10:0] rom_addr;
	logic [7:0]  font_word;
	rgb_t        rgb_next;
	logic        key_req, key_ack, alu_start, alu_done;
	key_event_t  key_evt;
	alu_req_t    alu_req;
	alu_rsp_t    alu_rsp;

	// ----------------------------------------------------------
	// Video path
	// ----------------------------------------------------------
	vga_sync #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
	) u_sync (.clk, .arst_n, .pix_x, .pix_y, .pixel_tick, .video_on, .hsync, .vsync);

	calc_painter u_painter (.pix_x, .pix_y, .pixel_tick, .mouse_x, .mouse_y, .font_word,
				.disp_value, .err, .rom_addr, .rgb_next);

	seg_font u_font (.rom_addr, .font_word);

	// ----------------------------------------------------------
	// Key and arithmetic path
	// ----------------------------------------------------------
	keypad_pointer u_pointer (.clk, .arst_n, .mouse_x, .mouse_y, .click, .key_ack,
				  .key_req, .key_evt);

	calc_ctrl #(.DATA_W(DATA_W)) u_ctrl (.clk, .arst_n, .key_req, .key_evt, .alu_done,
					     .alu_rsp, .key_ack, .alu_start, .alu_req,
					     .disp_value, .err);

	calc_alu #(.DATA_W(DATA_W)) u_alu (.clk, .arst_n, .alu_start, .alu_req, .alu_done,
					   .alu_rsp);

	// Pixel register, black in blanking
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			rgb <= BLACK;
		else if (pixel_tick)
			rgb <= video_on ? rgb_next : BLACK;
	end

endmodule

// ==== keypad_pointer.sv ====
`timescale 1ns/1ps
// Click is asynchronous and unbounced; pointer position is sampled on the click edge only
module keypad_pointer import calc_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [9:0] mouse_x,
	input  logic [9:0] mouse_y,
	input  logic       click,
	input  logic       key_ack,
	output logic       key_req,
	output key_event_t key_evt
);
	logic [2:0] click_q;     // Two sync stages, then history
	logic       click_rise;
	logic       on_key;
	key_code_t  hit_code;
	logic       launch;      // New event accepted

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			click_q <= '0;
		else
			click_q <= {click_q[1:0], click};
	end
	assign click_rise = click_q[1] && !click_q[2];

	// Cell under the pointer
	always_comb
	begin
		on_key = key_map(mouse_y[9:6], mouse_x[9:5], hit_code);
	end

	// Only when both handshake lines are back low
	assign launch = click_rise && on_key && !key_req && !key_ack;

	// ----------------------------------------------------------
	// Four-phase request side
	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			key_req <= 1'b0;
		else if (key_req)
			key_req <= !key_ack;  // Drop once taken
		else if (launch)
			key_req <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			key_evt.code <= hit_code;
	end

	// Ack back low one clock after the request drops
	a_ack_drops: assert property (@(posedge clk) disable iff (!arst_n)
		!$past(key_req) |-> !key_ack);

endmodule

// ==== seg_font.sv ====
`timescale 1ns/1ps
// Segment glyphs in an 8x16 cell; only 0-9, A-F, C, E and + - x / = are drawn
module seg_font (
	input  logic [10:0] rom_addr,   // Char code, then row
	output logic [7:0]  font_word   // Bit 7 is the leftmost pixel
);
	localparam logic [7:0] HBAR  = 8'b0111_1110;
	localparam logic [7:0] LEFT  = 8'b0100_0000;
	localparam logic [7:0] RIGHT = 8'b0000_0010;
	localparam logic [7:0] MID   = 8'b0001_1000;

	logic [6:0]  char_code;
	logic [3:0]  row;
	logic [10:0] seg;  // a b c d e f g, centre stroke, slash, backslash, twin bars
	logic        upper, lower, diag;
	logic [2:0]  slash_col, back_col;

	assign char_code = rom_addr[10:4];
	assign row       = rom_addr[3:0];

	always_comb
	begin
		case (char_code)
			7'h30:   seg = 11'h03F;  // 0
			7'h31:   seg = 11'h006;
			7'h32:   seg = 11'h05B;
			7'h33:   seg = 11'h04F;
			7'h34:   seg = 11'h066;
			7'h35:   seg = 11'h06D;
			7'h36:   seg = 11'h07D;
			7'h37:   seg = 11'h007;
			7'h38:   seg = 11'h07F;
			7'h39:   seg = 11'h06F;  // 9
			7'h41:   seg = 11'h077;  // A
			7'h42:   seg = 11'h07C;  // Lower case b shape
			7'h43:   seg = 11'h039;  // C, also the clear key
			7'h44:   seg = 11'h05E;  // Lower case d shape
			7'h45:   seg = 11'h079;  // E, also the error mark
			7'h46:   seg = 11'h071;
			7'h2B:   seg = 11'h0C0;  // + middle bar and centre stroke
			7'h2D:   seg = 11'h040;  // -
			7'h78:   seg = 11'h300;  // x both diagonals
			7'h2F:   seg = 11'h100;  // /
			7'h3D:   seg = 11'h400;  // =
			default: seg = '0;       // Blank
		endcase
	end

	// Row bands and diagonal columns
	assign upper     = (row >= 4'd1) && (row <= 4'd7);
	assign lower     = (row >= 4'd7) && (row <= 4'd13);
	assign diag      = (row >= 4'd2) && (row <= 4'd13);
	assign slash_col = 3'(((4'd13 - row) >> 1) + 4'd1);
	assign back_col  = 3'(((row - 4'd2) >> 1) + 4'd1);

	assign font_word = ({8{seg[0] && row == 4'd1}} & HBAR)
			 | ({8{seg[1] && upper}} & RIGHT)
			 | ({8{seg[2] && lower}} & RIGHT)
			 | ({8{seg[3] && row == 4'd13}} & HBAR)
			 | ({8{seg[4] && lower}} & LEFT)
			 | ({8{seg[5] && upper}} & LEFT)
			 | ({8{seg[6] && row == 4'd7}} & HBAR)
			 | ({8{seg[7] && row >= 4'd4 && row <= 4'd10}} & MID)
			 | ({8{seg[8] && diag}} & (8'h80 >> slash_col))
			 | ({8{seg[9] && diag}} & (8'h80 >> back_col))
			 | ({8{seg[10] && (row == 4'd5 || row == 4'd9)}} & HBAR);

endmodule

// ==== sources.f ====
calc_pkg.sv
vga_sync.sv
seg_font.sv
keypad_pointer.sv
calc_alu.sv
calc_ctrl.sv
calc_painter.sv
calc_top.sv
tb_clkgen.sv
tb_calc.sv

// ==== tb_calc.sv ====
`timescale 1ns/1ps
// Runs about two frames; the cursor check needs the pointer parked before the first vsync
module tb_calc import calc_pkg::*; ();
	localparam int LINE_CLKS  = 1600;             // 800 ticks of two clocks
	localparam int FRAME_CLKS = LINE_CLKS * 525;
	localparam int HS_LOW     = 2 * 96;
	localparam int VS_LOW     = 2 * LINE_CLKS;
	localparam int HS_START   = 656;              // First pix_x of the hsync pulse
	localparam int VS_START   = 490;              // First line of the vsync pulse
	localparam int MAX_CYCLES = 2 * FRAME_CLKS + 320000;  // Two frames plus key traffic
	localparam int KEY_WAIT   = 200;              // Longest press, divide included
	localparam int PARK_X     = 300;              // Clear of bars, keys and readout
	localparam int PARK_Y     = 40;

	logic        clk, arst_n, click;
	logic [9:0]  mouse_x, mouse_y;
	logic        hsync, vsync, err;
	rgb_t        rgb;
	logic [15:0] disp_value;

	int          seed = 54318;
	int          errors = 0;
	int          checks = 0;
	int          presses = 0;
	int          cursor_px = 0;
	int          cycles = 0;
	logic [15:0] exp_val;
	logic        exp_err, chk, rst_chk;

	// Pixel tracker state, all for the clock after the current edge
	logic        hs_q, vs_q, synced;
	int          hpos, vline, vs_falls;
	int          hs_low, hs_per, vs_low, vs_per;
	int          px;
	logic        in_cursor, in_blank;

	tb_clkgen #(.PERIOD_NS(100), .RESET_CYCLES(8)) u_clk (.clk, .arst_n);

	calc_top DUT (.clk, .arst_n, .mouse_x, .mouse_y, .click, .hsync, .vsync, .rgb,
		      .disp_value, .err);

	// ----------------------------------------------------------
	// Sync counters and pixel tracker
	// ----------------------------------------------------------
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hs_q     <= 1'b1;
			vs_q     <= 1'b1;
			synced   <= 1'b0;
			hpos     <= 0;
			vline    <= 0;
			vs_falls <= 0;
			hs_low   <= 0;
			vs_low   <= 0;
			hs_per   <= 0;
			vs_per   <= 0;
		end
		else
		begin
			hs_q   <= hsync;
			vs_q   <= vsync;
			hs_low <= hsync ? 0 : hs_low + 1;  // Low run length
			vs_low <= vsync ? 0 : vs_low + 1;
			hs_per <= (hs_q && !hsync) ? 1 : (hs_per != 0) ? hs_per + 1 : 0;
			vs_per <= (vs_q && !vsync) ? 1 : (vs_per != 0) ? vs_per + 1 : 0;
			if (vs_q && !vsync)
			begin
				synced   <= 1'b1;
				vs_falls <= vs_falls + 1;
				hpos     <= LINE_CLKS - 1;  // Second clock of pixel 799
				vline    <= VS_START - 1;
			end
			else if (hs_q && !hsync)
				hpos <= 2 * (HS_START - 1) + 1;  // Second clock of pixel 655
			else if (hpos == LINE_CLKS - 1)
			begin
				hpos  <= 0;
				vline <= (vline == 524) ? 0 : vline + 1;
			end
			else
				hpos <= hpos + 1;
			if (synced && in_cursor)
				cursor_px <= cursor_px + 1;
		end
	end

	assign px        = hpos / 2;
	// Box covers the four pixels past the pointer in each direction
	assign in_cursor = px > int'(mouse_x) && px < int'(mouse_x) + 5 &&
			   vline > int'(mouse_y) && vline < int'(mouse_y) + 5;
	assign in_blank  = px >= 640 || vline >= 480;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("Timeout: simulation still running after %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Checks
	// ----------------------------------------------------------
	a_display: assert property (@(posedge clk) disable iff (!arst_n)
		chk |-> disp_value == exp_val && err == exp_err)
		else
		begin
			errors++;
			$display("FAIL %0t ns: display %h err %b, expected %h err %b", $time,
				 disp_value, err, exp_val, exp_err);
		end
	a_reset_black: assert property (@(posedge clk) disable iff (!arst_n)
		rst_chk |-> rgb == BLACK)
		else
		begin
			errors++;
			$display("FAIL %0t ns: rgb %b after reset, expected black", $time, rgb);
		end
	a_hs_width: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(hsync) |-> hs_low == HS_LOW)
		else
		begin
			errors++;
			$display("FAIL %0t ns: hsync low for %0d clocks", $time, hs_low);
		end
	a_hs_period: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(hsync) && hs_per != 0 |-> hs_per == LINE_CLKS)
		else
		begin
			errors++;
			$display("FAIL %0t ns: line took %0d clocks", $time, hs_per);
		end
	a_vs_width: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(vsync) |-> vs_low == VS_LOW)
		else
		begin
			errors++;
			$display("FAIL %0t ns: vsync low for %0d clocks", $time, vs_low);
		end
	a_vs_period: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(vsync) && vs_per != 0 |-> vs_per == FRAME_CLKS)
		else
		begin
			errors++;
			$display("FAIL %0t ns: frame took %0d clocks", $time, vs_per);
		end
	a_cursor: assert property (@(posedge clk) disable iff (!arst_n)
		synced && in_cursor |-> rgb == GREEN)
		else
		begin
			errors++;
			$display("FAIL %0t ns: rgb %b at cursor pixel %0d,%0d", $time, rgb, px, vline);
		end
	a_blank: assert property (@(posedge clk) disable iff (!arst_n)
		synced && in_blank |-> rgb == BLACK)
		else
		begin
			errors++;
			$display("FAIL %0t ns: rgb %b in blanking at %0d,%0d", $time, rgb, px, vline);
		end

	// ----------------------------------------------------------
	// Stimulus helpers
	// ----------------------------------------------------------
	function automatic int expected_result(input key_code_t op, input int a, input int b);
		case (op)
			K_ADD:   return (a + b) & 'hFFFF;
			K_SUB:   return (a - b) & 'hFFFF;  // Two's complement wrap
			K_MUL:   return (a * b) & 'hFFFF;
			default: return a / b;
		endcase
	endfunction

	function automatic int pick_operand(input key_code_t op);
		if (op == K_DIV)
			return 1 + ($unsigned($random(seed)) % 300);  // Nonzero, small for real quotients
		return $unsigned($random(seed)) % 65536;
	endfunction

	// Centre of the key cell, straight from the keypad layout
	function automatic void key_position(input key_code_t k, output int x, output int y);
		int row, col;
		row = 6;
		col = 0;  // Zero key alone on the last row
		if (k >= K_1 && k <= K_9)
		begin
			row = 5 - (int'(k) - 1) / 3;
			col = (int'(k) - 1) % 3;
		end
		else if (k > K_9)
		begin
			row = (k == K_MUL || k == K_DIV) ? 3 : (k == K_ADD || k == K_SUB) ? 4 : 5;
			col = (k == K_MUL || k == K_ADD || k == K_CLR) ? 3 : 4;
		end
		x = (6 + 2 * col) * 32 + 16;
		y = row * 64 + 32;
	endfunction

	function automatic logic ctrl_idle();
		return !DUT.key_req && !DUT.key_ack && !DUT.alu_start &&
		       DUT.u_ctrl.state != ST_WAIT_ALU;
	endfunction

	task automatic press_key(input key_code_t k);
		int   x, y, n;
		logic seen;
		key_position(k, x, y);
		seen = 1'b0;
		n = 0;
		@(posedge clk);
		#10;
		mouse_x = 10'(x);
		mouse_y = 10'(y);
		click   = 1'b1;
		repeat (4)
		begin
			@(posedge clk);
			#10;
			seen |= DUT.key_ack;
		end
		click = 1'b0;
		while (!(seen && ctrl_idle()) && n < KEY_WAIT)  // Handshake closed, ALU idle
		begin
			@(posedge clk);
			#10;
			seen |= DUT.key_ack;
			n++;
		end
		presses++;
		if (!(seen && ctrl_idle()))
		begin
			errors++;
			$display("Key %s was never acknowledged or the ALU never finished", k.name());
		end
	endtask

	task automatic enter_number(input int v);
		int digs[5];
		int n;
		n = 0;
		do
		begin
			digs[n] = v % 10;
			v = v / 10;
			n++;
		end
		while (v != 0);
		for (int i = n - 1; i >= 0; i--)
			press_key(key_code_t'(4'(digs[i])));  // Most significant first
	endtask

	task automatic check_display(input logic [15:0] v, input logic e);
		@(posedge clk);
		#10;
		exp_val = v;
		exp_err = e;
		chk     = 1'b1;
		@(posedge clk);
		#10 chk = 1'b0;
		checks++;
	endtask

	// ----------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------
	initial
	begin
		key_code_t ops[4];
		key_code_t op, op2, op3;
		int        a, b, r, n, d;
		ops     = '{K_ADD, K_SUB, K_MUL, K_DIV};
		mouse_x = '0;
		mouse_y = '0;
		click   = 1'b0;
		chk     = 1'b0;
		rst_chk = 1'b0;
		exp_val = '0;
		exp_err = 1'b0;
		wait (arst_n);
		@(posedge clk);
		#10 rst_chk = 1'b1;
		@(posedge clk);
		#10 rst_chk = 1'b0;
		check_display(16'd0, 1'b0);

		// Digit accumulation, five digits may wrap
		for (int run = 0; run < 4; run++)
		begin
			press_key(K_CLR);
			n = 1 + ($unsigned($random(seed)) % 5);
			r = 0;
			for (int i = 0; i < n; i++)
			begin
				d = $unsigned($random(seed)) % 10;
				press_key(key_code_t'(4'(d)));
				r = (r * 10 + d) & 'hFFFF;
			end
			check_display(16'(r), 1'b0);
		end

		// Each operator, then a chained pair on the result
		for (int i = 0; i < 4; i++)
		begin
			op  = ops[i];
			op2 = ops[(i + 1) % 4];
			op3 = ops[(i + 2) % 4];
			press_key(K_CLR);
			a = pick_operand(K_ADD);
			enter_number(a);
			check_display(16'(a), 1'b0);
			press_key(op);
			b = pick_operand(op);
			enter_number(b);
			press_key(K_EQ);
			r = expected_result(op, a, b);
			check_display(16'(r), 1'b0);
			press_key(op2);
			b = pick_operand(op2);
			enter_number(b);
			press_key(op3);  // Runs op2 first
			r = expected_result(op2, r, b);
			check_display(16'(r), 1'b0);
			b = pick_operand(op3);
			enter_number(b);
			press_key(K_EQ);
			r = expected_result(op3, r, b);
			check_display(16'(r), 1'b0);
			press_key(K_CLR);
			check_display(16'd0, 1'b0);
		end

		// Divide by zero locks out everything but clear
		press_key(K_CLR);
		enter_number(pick_operand(K_ADD));
		press_key(K_DIV);
		press_key(K_0);
		press_key(K_EQ);
		check_display(16'd0, 1'b1);  // Last entry stays shown
		press_key(K_5);
		press_key(K_7);
		check_display(16'd0, 1'b1);
		press_key(K_CLR);
		check_display(16'd0, 1'b0);
		press_key(K_3);
		check_display(16'd3, 1'b0);

		// Park for the cursor frame
		@(posedge clk);
		#10;
		mouse_x = 10'(PARK_X);
		mouse_y = 10'(PARK_Y);
		wait (vs_falls >= 2);
		@(posedge clk);
		if (cursor_px != 32)
		begin
			errors++;
			$display("Cursor box was scanned for %0d clocks instead of 32", cursor_px);
		end

		$display("Checks %0d, key presses %0d, cursor clocks %0d, errors %0d",
			 checks, presses, cursor_px, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps
// Clock runs from time zero; reset is released 10 ns after a rising edge, like the stimulus
module tb_clkgen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic arst_n
);
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;  // Held from time zero
		repeat (RESET_CYCLES) @(posedge clk);
		#10 arst_n = 1'b1;  // Same skew as the input drive
	end

endmodule

// ==== vga_sync.sv ====
`timescale 1ns/1ps
// Pixel tick is half the input clock; syncs are active low; totals must fit in 10 bits
module vga_sync #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT  = 16,
	parameter int H_SYNC   = 96,
	parameter int H_BACK   = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT  = 10,
	parameter int V_SYNC   = 2,
	parameter int V_BACK   = 33
) (
	input  logic       clk,
	input  logic       arst_n,
	output logic [9:0] pix_x,
	output logic [9:0] pix_y,
	output logic       pixel_tick,
	output logic       video_on,
	output logic       hsync,
	output logic       vsync
);
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800 ticks
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525 lines
	localparam int H_SYNC0 = H_ACTIVE + H_FRONT;
	localparam int V_SYNC0 = V_ACTIVE + V_FRONT;

	logic       tick_q;
	logic [9:0] h_next;
	logic [9:0] v_next;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			tick_q <= 1'b0;
		else
			tick_q <= ~tick_q;  // Divide by two
	end
	assign pixel_tick = tick_q;

	// Next position, line wrap carries into the frame counter
	always_comb
	begin
		h_next = pix_x + 10'd1;
		v_next = pix_y;
		if (pix_x == 10'(H_TOTAL - 1))
		begin
			h_next = '0;
			v_next = (pix_y == 10'(V_TOTAL - 1)) ? '0 : pix_y + 10'd1;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix_x <= '0;
			pix_y <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else if (pixel_tick)
		begin
			pix_x <= h_next;
			pix_y <= v_next;
			hsync <= !(h_next >= 10'(H_SYNC0) && h_next < 10'(H_SYNC0 + H_SYNC));  // Aligned
			vsync <= !(v_next >= 10'(V_SYNC0) && v_next < 10'(V_SYNC0 + V_SYNC));
		end
	end

	assign video_on = (pix_x < 10'(H_ACTIVE)) && (pix_y < 10'(V_ACTIVE));

	a_line_len: assert property (@(posedge clk) disable iff (!arst_n) pix_x < 10'(H_TOTAL));

endmodule
